// File: logic/prof_consts.svh
`ifndef PROF_CONSTS_SVH
`define PROF_CONSTS_SVH

// Counter and record value width
`define PROF_CNT_WIDTH 32

// Counter bank sizes
`define PROF_NUM_STALL 8
`define PROF_NUM_EVENT 8
`define PROF_NUM_CNT   16

// Initial and maximum readout credits
`define PROF_CREDITS 4

// CSR port
`define PROF_CSR_WIDTH 2
`define PROF_CSR_CTRL  2'd0
`define PROF_CSR_SNAP  2'd1

`endif

// File: logic/prof_pkg.sv
`include "prof_consts.svh"

package prof_pkg;

  // Stall causes, highest priority first; value is also the counter index
  typedef enum logic [2:0] {
    e_stall_ic_miss     = 3'd0,
    e_stall_br_ovr      = 3'd1,
    e_stall_mispredict  = 3'd2,
    e_stall_control_haz = 3'd3,
    e_stall_data_haz    = 3'd4,
    e_stall_struct_haz  = 3'd5,
    e_stall_dc_miss     = 3'd6,
    e_stall_unknown     = 3'd7
  } stall_cause_e;

  // Pipeline status seen at commit
  typedef struct packed {
    logic instret;
    logic ic_valid;
    logic ic_ready;
    logic dc_valid;
    logic dc_ready;
    logic br_ovr;
    logic mispredict;
    logic control_haz;
    logic data_haz;
    logic struct_haz;
  } core_sig_s;

  // Memory side status, AXI handshakes plus L2 serving flags
  typedef struct packed {
    logic arvalid;
    logic arready;
    logic rlast;
    logic awvalid;
    logic awready;
    logic bvalid;
    logic l2_serving_dc;
    logic l2_serving_evict;
  } mem_sig_s;

  typedef struct packed {
    logic en;
    logic freeze;
  } prof_cfg_s;

  localparam int unsigned rec_idx_w = $clog2(`PROF_NUM_CNT);

  typedef struct packed {
    logic [rec_idx_w-1:0]       idx;
    logic [`PROF_CNT_WIDTH-1:0] value;
  } prof_rec_s;

  // Event counter indexes, following the 8 stall counters
  localparam int unsigned mcycle_idx       = 8;
  localparam int unsigned minstret_idx     = 9;
  localparam int unsigned ic_req_idx       = 10;
  localparam int unsigned ic_miss_idx      = 11;
  localparam int unsigned dc_miss_idx      = 12;
  localparam int unsigned dma_ic_idx       = 13;
  localparam int unsigned dma_dc_fetch_idx = 14;
  localparam int unsigned dma_dc_evict_idx = 15;

endpackage

// File: logic/stall_classifier.sv
module stall_classifier (
  input  prof_pkg::core_sig_s    core_i,
  output logic                   stall_v_o,
  output prof_pkg::stall_cause_e cause_o
);

  logic ic_miss;
  logic dc_miss;

  // A cycle without retirement is a stall
  assign stall_v_o = ~core_i.instret;

  // Cache misses show up as ready low
  assign ic_miss = ~core_i.ic_ready;
  assign dc_miss = ~core_i.dc_ready;

  // Fixed priority, front end first
  always_comb begin
    if (ic_miss) begin
      cause_o = prof_pkg::e_stall_ic_miss;
    end else if (core_i.br_ovr) begin
      cause_o = prof_pkg::e_stall_br_ovr;
    end else if (core_i.mispredict) begin
      cause_o = prof_pkg::e_stall_mispredict;
    end else if (core_i.control_haz) begin
      cause_o = prof_pkg::e_stall_control_haz;
    end else if (core_i.data_haz) begin
      cause_o = prof_pkg::e_stall_data_haz;
    end else if (core_i.struct_haz) begin
      cause_o = prof_pkg::e_stall_struct_haz;
    end else if (dc_miss) begin
      cause_o = prof_pkg::e_stall_dc_miss;
    end else begin
      // Nothing we know of
      cause_o = prof_pkg::e_stall_unknown;
    end
  end

endmodule

// File: logic/dma_tracker.sv
module dma_tracker (
  input  logic               clk_i,
  input  logic               reset_i,
  input  prof_pkg::mem_sig_s mem_i,
  output logic               dma_ic_o,
  output logic               dma_dc_fetch_o,
  output logic               dma_dc_evict_o
);

  // Source tags
  localparam logic [1:0] src_ic       = 2'b00;
  localparam logic [1:0] src_dc_fetch = 2'b01;
  localparam logic [1:0] src_dc_evict = 2'b10;

  logic       rd_acc;
  logic       wr_acc;
  logic [1:0] acc_src;
  logic       rd_pend_r;
  logic       wr_pend_r;
  logic [1:0] rd_src_r;
  logic [1:0] wr_src_r;
  logic       rd_pend;
  logic       wr_pend;
  logic [1:0] rd_src;
  logic [1:0] wr_src;

  assign rd_acc  = mem_i.arvalid & mem_i.arready;
  assign wr_acc  = mem_i.awvalid & mem_i.awready;
  assign acc_src = mem_i.l2_serving_dc ? (mem_i.l2_serving_evict ? src_dc_evict : src_dc_fetch)
                                       : src_ic;

  // Pending flags, new acceptance wins over completion
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rd_pend_r <= 1'b0;
      wr_pend_r <= 1'b0;
    end else begin
      if (rd_acc | mem_i.rlast) rd_pend_r <= rd_acc;
      if (wr_acc | mem_i.bvalid) wr_pend_r <= wr_acc;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rd_acc) rd_src_r <= acc_src;
    if (wr_acc) wr_src_r <= acc_src;
  end

  // Bypass so the acceptance cycle already counts
  assign rd_pend = rd_acc | rd_pend_r;
  assign wr_pend = wr_acc | wr_pend_r;
  assign rd_src  = rd_acc ? acc_src : rd_src_r;
  assign wr_src  = wr_acc ? acc_src : wr_src_r;

  assign dma_ic_o       = (rd_pend & (rd_src == src_ic)) | (wr_pend & (wr_src == src_ic));
  assign dma_dc_fetch_o = (rd_pend & (rd_src == src_dc_fetch))
                        | (wr_pend & (wr_src == src_dc_fetch));
  assign dma_dc_evict_o = (rd_pend & (rd_src == src_dc_evict))
                        | (wr_pend & (wr_src == src_dc_evict));

endmodule

// File: logic/counter_bank.sv
`include "prof_consts.svh"

module counter_bank #(
  parameter int unsigned NUM_CNT = 8
) (
  input  logic                                      clk_i,
  input  logic                                      reset_i,
  input  prof_pkg::prof_cfg_s                       cfg_i,
  input  logic [NUM_CNT-1:0]                        up_i,
  output logic [NUM_CNT-1:0][`PROF_CNT_WIDTH-1:0]   count_o
);

  logic [NUM_CNT-1:0][`PROF_CNT_WIDTH-1:0] cnt_r;

  // Freeze clears, then en gates the increments
  always_ff @(posedge clk_i) begin
    if (reset_i | cfg_i.freeze) begin
      cnt_r <= '0;
    end else if (cfg_i.en) begin
      for (int i = 0; i < NUM_CNT; i++) begin
        // Wraps at 2^width
        if (up_i[i]) begin
          cnt_r[i] <= cnt_r[i] + 1'b1;
        end
      end
    end
  end

  assign count_o = cnt_r;

endmodule

// File: logic/prof_csr.sv
`include "prof_consts.svh"

module prof_csr (
  input  logic                       clk_i,
  input  logic                       reset_i,
  input  logic                       csr_we_i,
  input  logic [`PROF_CSR_WIDTH-1:0] csr_addr_i,
  input  logic [`PROF_CSR_WIDTH-1:0] csr_wdata_i,
  output prof_pkg::prof_cfg_s        cfg_o,
  output logic                       snap_o
);

  prof_pkg::prof_cfg_s cfg_r;
  logic                snap_r;
  logic                ctrl_we;
  logic                snap_we;

  assign ctrl_we = csr_we_i & (csr_addr_i == `PROF_CSR_CTRL);
  assign snap_we = csr_we_i & (csr_addr_i == `PROF_CSR_SNAP);

  // Control register, bit 0 en and bit 1 freeze
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      cfg_r <= '0;
    end else if (ctrl_we) begin
      cfg_r.en     <= csr_wdata_i[0];
      cfg_r.freeze <= csr_wdata_i[1];
    end
  end

  // Snapshot strobe, high for the cycle after the write
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      snap_r <= 1'b0;
    end else begin
      snap_r <= snap_we;
    end
  end

  assign cfg_o  = cfg_r;
  assign snap_o = snap_r;

endmodule

// File: logic/prof_readout.sv
`include "prof_consts.svh"

module prof_readout (
  input  logic                                            clk_i,
  input  logic                                            reset_i,
  input  logic                                            snap_i,
  input  logic                                            credit_i,
  input  logic [`PROF_NUM_CNT-1:0][`PROF_CNT_WIDTH-1:0]   counts_i,
  output logic                                            rec_v_o,
  output prof_pkg::prof_rec_s                             rec_o,
  output logic                                            busy_o
);

  localparam int unsigned cred_w = $clog2(`PROF_CREDITS + 1);
  localparam logic [cred_w-1:0] cred_max = cred_w'(`PROF_CREDITS);
  localparam logic [prof_pkg::rec_idx_w-1:0] last_idx = prof_pkg::rec_idx_w'(`PROF_NUM_CNT - 1);

  logic [`PROF_NUM_CNT-1:0][`PROF_CNT_WIDTH-1:0] snap_q;
  logic [prof_pkg::rec_idx_w-1:0]                idx_r;
  logic [cred_w-1:0]                             credits_r;
  logic                                          busy_r;
  logic                                          take_snap;

  // Snapshot only when idle
  assign take_snap = snap_i & ~busy_r;

  always_ff @(posedge clk_i) begin
    if (take_snap) begin
      snap_q <= counts_i;
    end
  end

  // Walk the index through the latched counters
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      busy_r <= 1'b0;
      idx_r  <= '0;
    end else if (take_snap) begin
      busy_r <= 1'b1;
      idx_r  <= '0;
    end else if (rec_v_o) begin
      if (idx_r == last_idx) begin
        busy_r <= 1'b0;
      end
      idx_r <= idx_r + 1'b1;
    end
  end

  // Credit counter, saturates at the maximum
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      credits_r <= cred_max;
    end else begin
      case ({credit_i, rec_v_o})
        2'b10: begin
          if (credits_r != cred_max) begin
            credits_r <= credits_r + 1'b1;
          end
        end
        2'b01: credits_r <= credits_r - 1'b1;
        default: credits_r <= credits_r;
      endcase
    end
  end

  // One record per cycle while credit lasts
  assign rec_v_o     = busy_r & (credits_r != '0);
  assign rec_o.idx   = idx_r;
  assign rec_o.value = snap_q[idx_r];
  assign busy_o      = busy_r;

endmodule

// File: logic/commit_profiler.sv
`include "prof_consts.svh"

module commit_profiler (
  input  logic                       clk_i,
  input  logic                       reset_i,
  input  prof_pkg::core_sig_s        core_i,
  input  prof_pkg::mem_sig_s         mem_i,
  input  logic                       csr_we_i,
  input  logic [`PROF_CSR_WIDTH-1:0] csr_addr_i,
  input  logic [`PROF_CSR_WIDTH-1:0] csr_wdata_i,
  input  logic                       credit_i,
  output logic                       rec_v_o,
  output prof_pkg::prof_rec_s        rec_o,
  output logic                       busy_o
);

  localparam int unsigned ev_base = `PROF_NUM_STALL;

  prof_pkg::prof_cfg_s    cfg;
  logic                   snap;
  logic                   stall_v;
  prof_pkg::stall_cause_e cause;
  logic                   dma_ic;
  logic                   dma_dc_fetch;
  logic                   dma_dc_evict;
  logic                   ic_ready_r;
  logic                   dc_ready_r;
  logic [`PROF_NUM_STALL-1:0] stall_up;
  logic [`PROF_NUM_EVENT-1:0] event_up;
  logic [`PROF_NUM_STALL-1:0][`PROF_CNT_WIDTH-1:0] stall_counts;
  logic [`PROF_NUM_EVENT-1:0][`PROF_CNT_WIDTH-1:0] event_counts;
  logic [`PROF_NUM_CNT-1:0][`PROF_CNT_WIDTH-1:0]   counts;

  stall_classifier classifier (.core_i(core_i), .stall_v_o(stall_v), .cause_o(cause));

  dma_tracker dma (
    .clk_i(clk_i), .reset_i(reset_i), .mem_i(mem_i),
    .dma_ic_o(dma_ic), .dma_dc_fetch_o(dma_dc_fetch), .dma_dc_evict_o(dma_dc_evict)
  );

  prof_csr csr (
    .clk_i(clk_i), .reset_i(reset_i), .csr_we_i(csr_we_i), .csr_addr_i(csr_addr_i),
    .csr_wdata_i(csr_wdata_i), .cfg_o(cfg), .snap_o(snap)
  );

  // Previous ready for miss edge detection
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      ic_ready_r <= 1'b0;
      dc_ready_r <= 1'b0;
    end else begin
      ic_ready_r <= core_i.ic_ready;
      dc_ready_r <= core_i.dc_ready;
    end
  end

  // One-hot stall cause
  always_comb begin
    stall_up = '0;
    stall_up[cause] = stall_v;
  end

  assign event_up[prof_pkg::mcycle_idx - ev_base]       = 1'b1;
  assign event_up[prof_pkg::minstret_idx - ev_base]     = core_i.instret;
  assign event_up[prof_pkg::ic_req_idx - ev_base]       = core_i.ic_valid & core_i.ic_ready;
  assign event_up[prof_pkg::ic_miss_idx - ev_base]      = ~core_i.ic_ready & ic_ready_r;
  assign event_up[prof_pkg::dc_miss_idx - ev_base]      = ~core_i.dc_ready & dc_ready_r;
  assign event_up[prof_pkg::dma_ic_idx - ev_base]       = dma_ic;
  assign event_up[prof_pkg::dma_dc_fetch_idx - ev_base] = dma_dc_fetch;
  assign event_up[prof_pkg::dma_dc_evict_idx - ev_base] = dma_dc_evict;

  counter_bank #(.NUM_CNT(`PROF_NUM_STALL)) stall_cnt (
    .clk_i(clk_i), .reset_i(reset_i), .cfg_i(cfg), .up_i(stall_up), .count_o(stall_counts)
  );

  counter_bank #(.NUM_CNT(`PROF_NUM_EVENT)) event_cnt (
    .clk_i(clk_i), .reset_i(reset_i), .cfg_i(cfg), .up_i(event_up), .count_o(event_counts)
  );

  // Stall counters take the low indexes
  assign counts = {event_counts, stall_counts};

  prof_readout readout (
    .clk_i(clk_i), .reset_i(reset_i), .snap_i(snap), .credit_i(credit_i), .counts_i(counts),
    .rec_v_o(rec_v_o), .rec_o(rec_o), .busy_o(busy_o)
  );

endmodule

// File: dv/prof_clk_gen.sv
module prof_clk_gen #(
  parameter int unsigned PERIOD = 40
) (
  output logic clk_o
);

  // Free running, starts low
  initial begin
    clk_o = 1'b0;
    forever #(PERIOD / 2) clk_o = ~clk_o;
  end

endmodule

// File: dv/tb_commit_profiler.sv
`include "prof_consts.svh"

module tb_commit_profiler;

  localparam int max_rows     = 16;
  localparam int rec_timeout  = 400;
  localparam int hold_cycles  = 20;

  // Retiring with both caches ready and no hazards
  localparam prof_pkg::core_sig_s idle_core = 10'b10101_00000;

  typedef int unsigned inc_t [`PROF_NUM_CNT];

  logic                       clk;
  logic                       reset;
  prof_pkg::core_sig_s        core;
  prof_pkg::mem_sig_s         mem;
  logic                       csr_we;
  logic [`PROF_CSR_WIDTH-1:0] csr_addr;
  logic [`PROF_CSR_WIDTH-1:0] csr_wdata;
  logic                       credit;
  logic                       rec_v;
  prof_pkg::prof_rec_s        rec;
  logic                       busy;

  // Phase table with one entry per row
  string               row_name [max_rows];
  prof_pkg::core_sig_s row_core [max_rows];
  int                  row_mem  [max_rows];
  int                  row_len  [max_rows];
  logic [1:0]          row_ctrl [max_rows];
  inc_t                row_inc  [max_rows];
  int                  num_rows;

  // Expected counter values so far
  int unsigned exp_tot [`PROF_NUM_CNT];
  int unsigned seed;

  prof_clk_gen #(.PERIOD(40)) clk_gen (.clk_o(clk));

  commit_profiler UUT (
    .clk_i(clk), .reset_i(reset), .core_i(core), .mem_i(mem),
    .csr_we_i(csr_we), .csr_addr_i(csr_addr), .csr_wdata_i(csr_wdata), .credit_i(credit),
    .rec_v_o(rec_v), .rec_o(rec), .busy_o(busy)
  );

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("Checks failed");
    $fatal(1);
  endtask

  task automatic compare_rec(input string tname, input prof_pkg::prof_rec_s exp_v,
                             input prof_pkg::prof_rec_s act_v);
    if (act_v !== exp_v) begin
      report_failure($sformatf("ERR %s: expected idx %0d value %0d, actual idx %0d value %0d",
                               tname, exp_v.idx, exp_v.value, act_v.idx, act_v.value));
    end
  endtask

  task automatic compare_flag(input string tname, input logic exp_v, input logic act_v);
    if (act_v !== exp_v) begin
      report_failure($sformatf("ERR %s: expected %b, actual %b", tname, exp_v, act_v));
    end
  endtask

  task automatic add_row(input string name, input prof_pkg::core_sig_s core_val,
                         input int mem_sel, input int len, input logic [1:0] ctrl,
                         input inc_t inc);
    row_name[num_rows] = name;
    row_core[num_rows] = core_val;
    row_mem[num_rows]  = mem_sel;
    row_len[num_rows]  = len;
    row_ctrl[num_rows] = ctrl;
    row_inc[num_rows]  = inc;
    num_rows++;
  endtask

  task automatic build_table();
    // Core bits run instret ic_valid ic_ready dc_valid dc_ready br_ovr mispredict
    // control_haz data_haz struct_haz
    // Ctrl bit 0 is en and bit 1 is freeze
    // Increments give the 8 stall causes in priority order followed by mcycle minstret
    // ic_req ic_miss dc_miss dma_ic dma_dc_fetch dma_dc_evict
    num_rows = 0;
    add_row("retire", 10'b11101_00000, 0, 6, 2'b01, '{0,0,0,0,0,0,0,0,6,6,6,0,0,0,0,0});
    add_row("stall_data", 10'b00101_00010, 0, 5, 2'b01, '{0,0,0,0,5,0,0,0,5,0,0,0,0,0,0,0});
    add_row("stall_unknown", 10'b00101_00000, 0, 3, 2'b01, '{0,0,0,0,0,0,0,3,3,0,0,0,0,0,0,0});
    add_row("prio_all", 10'b00101_11111, 0, 4, 2'b01, '{0,4,0,0,0,0,0,0,4,0,0,0,0,0,0,0});
    add_row("prio_mispred", 10'b00101_01110, 0, 4, 2'b01, '{0,0,4,0,0,0,0,0,4,0,0,0,0,0,0,0});
    add_row("prio_struct_dc", 10'b00100_00001, 0, 4, 2'b01, '{0,0,0,0,0,4,0,0,4,0,0,0,1,0,0,0});
    add_row("ic_miss", 10'b01001_10000, 0, 5, 2'b01, '{5,0,0,0,0,0,0,0,5,0,0,1,0,0,0,0});
    add_row("dc_miss", 10'b00110_00000, 0, 3, 2'b01, '{0,0,0,0,0,0,3,0,3,0,0,0,1,0,0,0});
    add_row("dma_rd_evict", 10'b10101_00000, 1, 6, 2'b01, '{0,0,0,0,0,0,0,0,6,6,0,0,0,0,0,4});
    add_row("dma_wr_ic", 10'b10101_00000, 2, 6, 2'b01, '{0,0,0,0,0,0,0,0,6,6,0,0,0,4,0,0});
    add_row("hold_en_low", 10'b00101_00010, 0, 5, 2'b00, '{0,0,0,0,0,0,0,0,0,0,0,0,0,0,0,0});
    add_row("freeze", 10'b11101_00000, 0, 5, 2'b11, '{0,0,0,0,0,0,0,0,0,0,0,0,0,0,0,0});
    add_row("after_freeze", 10'b11101_00000, 0, 4, 2'b01, '{0,0,0,0,0,0,0,0,4,4,4,0,0,0,0,0});
  endtask

  // Memory side stimulus for cycle c of a row
  function automatic prof_pkg::mem_sig_s mem_step(input int sel, input int c);
    // Bits run arvalid arready rlast awvalid awready bvalid l2_serving_dc l2_serving_evict
    prof_pkg::mem_sig_s m;
    m = '0;
    if (sel == 1) begin
      // Read taken while L2 serves a dc evict with rlast three cycles on
      if (c == 0) m = 8'b110_000_11;
      if (c == 3) m = 8'b001_000_00;
    end else if (sel == 2) begin
      // Write taken while L2 serves ic amid evict flags that must not matter
      if (c == 1) m = 8'b000_110_00;
      else if (c == 4) m = 8'b000_001_00;
      else if (c < 4) m = 8'b000_000_11;
    end
    return m;
  endfunction

  task automatic apply_row(input int r);
    // Ctrl write one cycle ahead and a clearing write in the last row cycle
    @(posedge clk);
    csr_we    <= 1'b1;
    csr_wdata <= row_ctrl[r];
    for (int c = 0; c < row_len[r]; c++) begin
      @(posedge clk);
      core      <= row_core[r];
      mem       <= mem_step(row_mem[r], c);
      csr_we    <= (c == row_len[r] - 1);
      csr_wdata <= '0;
    end
    @(posedge clk);
    core   <= idle_core;
    mem    <= '0;
    csr_we <= 1'b0;
  endtask

  task automatic take_snapshot();
    @(posedge clk);
    csr_we   <= 1'b1;
    csr_addr <= `PROF_CSR_SNAP;
    @(posedge clk);
    csr_we   <= 1'b0;
    csr_addr <= `PROF_CSR_CTRL;
  endtask

  // Receiver side that withholds credit for hold cycles and then returns it at random
  task automatic collect_records(input string tname, input int hold);
    prof_pkg::prof_rec_s exp_rec;
    int   got;
    int   owed;
    int   cyc;
    logic give;
    got  = 0;
    owed = 0;
    cyc  = 0;
    while (got < `PROF_NUM_CNT) begin
      if (cyc == rec_timeout + hold) begin
        report_failure($sformatf("%s: timed out waiting for record %0d", tname, got));
      end
      @(negedge clk);
      // Busy from the snapshot edge on
      compare_flag({tname, "_busy"}, cyc > 0, busy);
      if (rec_v) begin
        exp_rec.idx   = prof_pkg::rec_idx_w'(got);
        exp_rec.value = exp_tot[got];
        compare_rec(tname, exp_rec, rec);
        got++;
        owed++;
      end
      if (hold > 0 && cyc == hold) begin
        compare_flag({tname, "_stops_at_credit_limit"}, 1'b1, got == `PROF_CREDITS);
      end
      @(posedge clk);
      give = (owed > 0) && (hold == 0 || (cyc >= hold && $urandom % 3 == 0));
      credit <= give;
      if (give) begin
        owed--;
      end
      cyc++;
    end
    // Busy drops with the last record
    @(negedge clk);
    compare_flag({tname, "_busy_done"}, 1'b0, busy);
    compare_flag({tname, "_rec_v_idle"}, 1'b0, rec_v);
    // Return what is still owed
    while (owed > 0) begin
      @(posedge clk);
      credit <= 1'b1;
      owed--;
    end
    @(posedge clk);
    credit <= 1'b0;
  endtask

  initial begin
    seed      = $urandom(20634);
    reset     = 1'b1;
    core      = idle_core;
    mem       = '0;
    csr_we    = 1'b0;
    csr_addr  = `PROF_CSR_CTRL;
    csr_wdata = '0;
    credit    = 1'b0;
    exp_tot   = '{default: 0};
    build_table();
    repeat (10) @(posedge clk);
    reset <= 1'b0;
    @(negedge clk);
    compare_flag("reset_rec_v", 1'b0, rec_v);
    compare_flag("reset_busy", 1'b0, busy);
    take_snapshot();
    collect_records("reset_snapshot", 0);
    for (int r = 0; r < num_rows; r++) begin
      apply_row(r);
      // Freeze wipes all counts so far
      if (row_ctrl[r][1]) begin
        exp_tot = '{default: 0};
      end
      for (int i = 0; i < `PROF_NUM_CNT; i++) begin
        exp_tot[i] += row_inc[r][i];
      end
      take_snapshot();
      collect_records(row_name[r], 0);
    end
    take_snapshot();
    collect_records("credit_backpressure", hold_cycles);
    $display("All checks passed");
    $finish;
  end

endmodule

// File: sim.f
+incdir+logic
logic/prof_pkg.sv
logic/stall_classifier.sv
logic/dma_tracker.sv
logic/counter_bank.sv
logic/prof_csr.sv
logic/prof_readout.sv
logic/commit_profiler.sv
dv/prof_clk_gen.sv
dv/tb_commit_profiler.sv
